/* project.f */
source/fpMulPkg.sv
source/fpMulBooth.sv
source/fpMulNorm.sv
source/fpMulRound.sv
source/fpMulChecker.sv
source/fpMulTop.sv
dv/tbClock.sv
dv/fpMulTb.sv

/* Makefile */
# Verilator build and run for the floating-point multiplier

VERILATOR ?= verilator
TOP       ?= fpMulTb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
FAIL_MSG  ?= ERRORS FOUND
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/fpMulTestdata.txt */
# columns: name rMode x y expected z expected ovrf expected udrf
# all values in hex except the name, rMode 0 rne 1 rtz 2 rdn 3 rup 4 rmm
oneTimesOne 0 3F800000 3F800000 3F800000 0 0
twoTimesThree 0 40000000 40400000 40C00000 0 0
productAboveTwo 0 3FC00000 3FC00000 40100000 0 0
tieOddRne 0 3F800001 3FC00000 3FC00002 0 0
tieEvenRne 0 3F800003 3FC00000 3FC00004 0 0
tieEvenRmm 4 3F800003 3FC00000 3FC00005 0 0
tieOddRtz 1 3F800001 3FC00000 3FC00001 0 0
unusedModeRne 7 3F800001 3FC00000 3FC00002 0 0
stickyRupPos 3 3F800001 3F800001 3F800003 0 0
stickyRdnPos 2 3F800001 3F800001 3F800002 0 0
stickyRdnNeg 2 BF800001 3F800001 BF800003 0 0
stickyRupNeg 3 BF800001 3F800001 BF800002 0 0
stickyRtzNeg 1 BF800001 3F800001 BF800002 0 0
bigRne 0 3FFFFFFF 3FFFFFFF 407FFFFE 0 0
bigRup 3 3FFFFFFF 3FFFFFFF 407FFFFF 0 0
roundCarryRup 3 3F800001 3FFFFFFE 40000000 0 0
roundCarryRtz 1 3F800001 3FFFFFFE 3FFFFFFF 0 0
zeroTimesNeg 0 00000000 C0000000 80000000 0 0
subnormTimesOne 0 00000001 3F800000 00000000 0 0
negSubnormTimesOne 0 80400000 3F800000 80000000 0 0
infTimesNeg 0 7F800000 C0000000 FF800000 0 0
nanInput 0 7FC00001 3F800000 7FC00000 0 0
nanTimesZero 0 FFFFFFFF 00000000 7FC00000 0 0
infTimesZero 0 FF800000 00000000 7FC00000 0 0
overflowPos 0 7F000000 40000000 7F800000 1 0
overflowNeg 0 7F000000 C0000000 FF800000 1 0
underflowPos 0 00800000 3F000000 00000000 0 1
underflowNeg 0 80800000 3F000000 80000000 0 1

/* dv/fpMulTb.sv */
`timescale 1ns/1ps

module fpMulTb
    import fpMulPkg::*;
();

    localparam int WaitLimit = 20;

    logic       clk;
    logic       rstN;
    logic       req;
    fpWord      x;
    fpWord      y;
    logic [2:0] rMode;
    logic       ack;
    fpWord      z;
    logic       ovrf;
    logic       udrf;

    int errors;
    int vectorCount;
    int seed;

    tbClock clockGen (
        .clk (clk),
        .rstN(rstN)
    );

    fpMulTop uut (
        .clk  (clk),
        .rstN (rstN),
        .req  (req),
        .x    (x),
        .y    (y),
        .rMode(rMode),
        .ack  (ack),
        .z    (z),
        .ovrf (ovrf),
        .udrf (udrf)
    );

    task automatic waitForReset();
        int count;
        count = 0;
        while (!rstN && count < WaitLimit) begin
            @(posedge clk);
            count++;
        end
        if (!rstN) begin
            $display("reset was never released");
            errors++;
        end
        #5;
    endtask

    // ack must stay low while no request is pending
    task automatic idleCycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #5;
            if (ack) begin
                $display("ack is high while req is low");
                errors++;
            end
        end
    endtask

    task automatic runHandshake(input string name, input logic [2:0] mode,
                                input logic [31:0] xv, input logic [31:0] yv,
                                input logic [31:0] zExp, input logic ovExp,
                                input logic udExp);
        int count;
        if (ack) begin
            $display("ack is already high before req for %s", name);
            errors++;
        end
        x.raw = xv;
        y.raw = yv;
        rMode = mode;
        req   = 1'b1;

        count = 0;
        while (!ack && count < WaitLimit) begin
            @(posedge clk);
            #5;
            count++;
        end
        if (!ack) begin
            $display("ack did not rise within %0d cycles for %s", WaitLimit, name);
            errors++;
        end else begin
            if (z.raw !== zExp) begin
                $display("Error %s: z expected %h actual %h", name, zExp, z.raw);
                errors++;
            end
            if (ovrf !== ovExp) begin
                $display("Error %s: ovrf expected %b actual %b", name, ovExp, ovrf);
                errors++;
            end
            if (udrf !== udExp) begin
                $display("Error %s: udrf expected %b actual %b", name, udExp, udrf);
                errors++;
            end
        end

        // release and wait for the unit to drop ack
        req   = 1'b0;
        count = 0;
        while (ack && count < WaitLimit) begin
            @(posedge clk);
            #5;
            count++;
        end
        if (ack) begin
            $display("ack did not fall within %0d cycles for %s", WaitLimit, name);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        int          status;
        int          fields;
        int          gap;
        string       line;
        string       name;
        logic [2:0]  mode;
        logic [31:0] xv;
        logic [31:0] yv;
        logic [31:0] zExp;
        logic        ovExp;
        logic        udExp;

        req         = 1'b0;
        x           = '0;
        y           = '0;
        rMode       = rmRne;
        errors      = 0;
        vectorCount = 0;
        seed        = 32'hd1ad_21af;

        waitForReset();
        idleCycles(3);

        fd = $fopen("dv/fpMulTestdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/fpMulTestdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                // skip blank lines and comment lines
                if (status != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h",
                                     name, mode, xv, yv, zExp, ovExp, udExp);
                    if (fields != 7) begin
                        $display("malformed vector line: %s", line);
                        errors++;
                    end else begin
                        runHandshake(name, mode, xv, yv, zExp, ovExp, udExp);
                        vectorCount++;
                        gap = $random(seed) & 3;
                        idleCycles(gap);
                    end
                end
            end
            $fclose(fd);
        end

        if (vectorCount == 0) begin
            $display("no vectors were run");
            errors++;
        end

        $display("%0d vectors checked, %0d errors", vectorCount, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset low for the first 3 rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rstN = 1'b1;
    end

endmodule

/* source/fpMulTop.sv */
`timescale 1ns/1ps

module fpMulTop
    import fpMulPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       req,
    input  fpWord      x,
    input  fpWord      y,
    input  logic [2:0] rMode,
    output logic       ack,
    output fpWord      z,
    output logic       ovrf,
    output logic       udrf
);

    localparam int ProdWidth = 48;

    // booth to norm
    logic                 boothValid;
    logic                 boothSign;
    logic signed [9:0]    boothExpSum;
    logic [1:0]           boothSpecKind;
    logic [ProdWidth-1:0] fracFull;
    logic [2:0]           boothRMode;

    // norm to round
    logic                 normValid;
    logic [26:0]          fracNorm;
    logic                 normShift;
    logic                 normSign;
    logic signed [9:0]    normExpSum;
    logic [1:0]           normSpecKind;
    logic [2:0]           normRMode;

    fpMulBooth #(
        .ProdWidth(ProdWidth)
    ) booth (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .ack       (ack),
        .x         (x),
        .y         (y),
        .rMode     (rMode),
        .boothValid(boothValid),
        .sign      (boothSign),
        .expSum    (boothExpSum),
        .specKind  (boothSpecKind),
        .fracFull  (fracFull),
        .rModeOut  (boothRMode)
    );

    fpMulNorm #(
        .ProdWidth(ProdWidth)
    ) norm (
        .clk        (clk),
        .rstN       (rstN),
        .boothValid (boothValid),
        .sign       (boothSign),
        .expSum     (boothExpSum),
        .specKind   (boothSpecKind),
        .fracFull   (fracFull),
        .rMode      (boothRMode),
        .normValid  (normValid),
        .fracNorm   (fracNorm),
        .normShift  (normShift),
        .signOut    (normSign),
        .expSumOut  (normExpSum),
        .specKindOut(normSpecKind),
        .rModeOut   (normRMode)
    );

    fpMulRound round (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .normValid(normValid),
        .fracNorm (fracNorm),
        .normShift(normShift),
        .sign     (normSign),
        .expSum   (normExpSum),
        .specKind (normSpecKind),
        .rMode    (normRMode),
        .z        (z),
        .ovrf     (ovrf),
        .udrf     (udrf),
        .ack      (ack)
    );

    fpMulChecker #(
        .ProdWidth(ProdWidth)
    ) crossChecks (
        .clk       (clk),
        .rstN      (rstN),
        .x         (x),
        .y         (y),
        .boothValid(boothValid),
        .fracFull  (fracFull),
        .normValid (normValid),
        .fracNorm  (fracNorm),
        .sign      (normSign),
        .ack       (ack),
        .z         (z)
    );

endmodule

/* source/fpMulChecker.sv */
`timescale 1ns/1ps

module fpMulChecker
    import fpMulPkg::*;
#(
    parameter int ProdWidth = 48
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  fpWord                x,
    input  fpWord                y,
    input  logic                 boothValid,
    input  logic [ProdWidth-1:0] fracFull,
    input  logic                 normValid,
    input  logic [26:0]          fracNorm,
    input  logic                 sign,
    input  logic                 ack,
    input  fpWord                z
);

    logic                 xZero;
    logic                 yZero;
    logic                 xSpecial;
    logic                 ySpecial;
    logic                 zeroCase;
    logic                 signXor;
    logic [ProdWidth-1:0] shifted;
    logic [26:0]          fracExpect;

    always_comb begin
        xZero    = (x.fields.exponent == 8'h00);
        yZero    = (y.fields.exponent == 8'h00);
        xSpecial = (x.fields.exponent == 8'hFF);
        ySpecial = (y.fields.exponent == 8'hFF);
        zeroCase = (xZero || yZero) && !xSpecial && !ySpecial;
        signXor  = x.fields.sign ^ y.fields.sign;

        // reference normalization of the booth product
        shifted    = fracFull << !fracFull[ProdWidth-1];
        fracExpect = {shifted[ProdWidth-1:ProdWidth-26], (shifted[ProdWidth-27:0] != '0)};
    end

    // operands are only guaranteed stable until req drops, so sample at ack rise
    zeroTimesNumber: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) && zeroCase |-> z.raw == {signXor, 31'd0});

    normSign: assert property (@(posedge clk) disable iff (!rstN)
        normValid |-> sign == signXor);

    // booth product as seen when the norm stage captured it
    normFraction: assert property (@(posedge clk) disable iff (!rstN)
        boothValid |=> fracNorm == $past(fracExpect));

    resultHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack |=> !ack || $stable(z));

endmodule

/* source/fpMulRound.sv */
`timescale 1ns/1ps

module fpMulRound
    import fpMulPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              req,
    input  logic              normValid,
    input  logic [26:0]       fracNorm,
    input  logic              normShift,
    input  logic              sign,
    input  logic signed [9:0] expSum,
    input  logic [1:0]        specKind,
    input  logic [2:0]        rMode,
    output fpWord             z,
    output logic              ovrf,
    output logic              udrf,
    output logic              ack
);

    logic              guard;
    logic              sticky;
    logic              lsb;
    logic              inexact;
    logic              inc;
    logic [24:0]       sigRounded;
    logic              carry;
    logic signed [9:0] expFinal;
    logic [22:0]       fracFinal;
    fpWord             zNext;
    logic              ovrfNext;
    logic              udrfNext;

    always_comb begin
        guard   = fracNorm[2];
        sticky  = |fracNorm[1:0];
        lsb     = fracNorm[3];
        inexact = guard || sticky;

        case (rMode)
            rmRtz:   inc = 1'b0;
            rmRdn:   inc = inexact && sign;
            rmRup:   inc = inexact && !sign;
            rmRmm:   inc = guard;
            // nearest-even, also for the unused codes
            default: inc = guard && (sticky || lsb);
        endcase

        sigRounded = {1'b0, fracNorm[26:3]} + {24'd0, inc};
        carry      = sigRounded[24];
        // on carry the significand is 10...0, the fraction is all zero
        fracFinal  = carry ? sigRounded[23:1] : sigRounded[22:0];
        expFinal   = expSum + $signed({9'd0, normShift}) + $signed({9'd0, carry});

        ovrfNext = 1'b0;
        udrfNext = 1'b0;
        case (specKind)
            skZero: begin
                zNext.raw = {sign, 31'd0};
            end
            skInf: begin
                zNext.raw = {sign, 8'hFF, 23'd0};
            end
            skNan: begin
                zNext.raw = qNan;
            end
            default: begin
                if (expFinal >= 10'sd255) begin
                    zNext.raw = {sign, 8'hFF, 23'd0};
                    ovrfNext  = 1'b1;
                end else if (expFinal < 10'sd1) begin
                    // no gradual underflow
                    zNext.raw = {sign, 31'd0};
                    udrfNext  = 1'b1;
                end else begin
                    zNext.fields.sign     = sign;
                    zNext.fields.exponent = expFinal[7:0];
                    zNext.fields.fraction = fracFinal;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack  <= 1'b0;
            ovrf <= 1'b0;
            udrf <= 1'b0;
        end else if (normValid) begin
            ack  <= 1'b1;
            ovrf <= ovrfNext;
            udrf <= udrfNext;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (normValid) begin
            z <= zNext;
        end
    end

    flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(ovrf && udrf));

endmodule

/* source/fpMulNorm.sv */
`timescale 1ns/1ps

module fpMulNorm
    import fpMulPkg::*;
#(
    parameter int ProdWidth = 48
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 boothValid,
    input  logic                 sign,
    input  logic signed [9:0]    expSum,
    input  logic [1:0]           specKind,
    input  logic [ProdWidth-1:0] fracFull,
    input  logic [2:0]           rMode,
    output logic                 normValid,
    output logic [26:0]          fracNorm,
    output logic                 normShift,
    output logic                 signOut,
    output logic signed [9:0]    expSumOut,
    output logic [1:0]           specKindOut,
    output logic [2:0]           rModeOut
);

    logic [ProdWidth-1:0] aligned;
    logic                 sticky;

    always_comb begin
        // product of two 1.x values lies in [1, 4)
        aligned = fracFull[ProdWidth-1] ? fracFull : {fracFull[ProdWidth-2:0], 1'b0};
        sticky  = |aligned[ProdWidth-27:0];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            normValid <= 1'b0;
        end else begin
            normValid <= boothValid;
        end
    end

    always_ff @(posedge clk) begin
        if (boothValid) begin
            fracNorm    <= {aligned[ProdWidth-1 -: 26], sticky};
            normShift   <= fracFull[ProdWidth-1];
            signOut     <= sign;
            expSumOut   <= expSum;
            specKindOut <= specKind;
            rModeOut    <= rMode;
        end
    end

    // booth classified the operands, so a normal product must lead with a one
    leadingOne: assert property (@(posedge clk) disable iff (!rstN)
        normValid && (specKindOut == skNormal) |-> fracNorm[26]);

endmodule

/* source/fpMulBooth.sv */
`timescale 1ns/1ps

module fpMulBooth
    import fpMulPkg::*;
#(
    parameter int ProdWidth = 48
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 req,
    input  logic                 ack,
    input  fpWord                x,
    input  fpWord                y,
    input  logic [2:0]           rMode,
    output logic                 boothValid,
    output logic                 sign,
    output logic signed [9:0]    expSum,
    output logic [1:0]           specKind,
    output logic [ProdWidth-1:0] fracFull,
    output logic [2:0]           rModeOut
);

    localparam int SigWidth = ProdWidth / 2;

    logic                busy;
    logic                ackSeen;
    logic                start;
    logic                accept;
    logic                xZero;
    logic                xInf;
    logic                xNan;
    logic                yZero;
    logic                yInf;
    logic                yNan;
    logic [1:0]          kind;
    logic [SigWidth-1:0] sigX;
    logic [SigWidth-1:0] sigY;

    assign accept = req && !busy;

    always_comb begin
        // subnormals are flushed, so exponent 0 means zero
        xZero = (x.fields.exponent == 8'h00);
        xInf  = (x.fields.exponent == 8'hFF) && (x.fields.fraction == 23'd0);
        xNan  = (x.fields.exponent == 8'hFF) && (x.fields.fraction != 23'd0);
        yZero = (y.fields.exponent == 8'h00);
        yInf  = (y.fields.exponent == 8'hFF) && (y.fields.fraction == 23'd0);
        yNan  = (y.fields.exponent == 8'hFF) && (y.fields.fraction != 23'd0);

        if (xNan || yNan || (xInf && yZero) || (yInf && xZero)) begin
            kind = skNan;
        end else if (xInf || yInf) begin
            kind = skInf;
        end else if (xZero || yZero) begin
            kind = skZero;
        end else begin
            kind = skNormal;
        end

        // hidden bit restored, zero operand forces a zero product
        sigX = xZero ? '0 : {1'b1, x.fields.fraction};
        sigY = yZero ? '0 : {1'b1, y.fields.fraction};
    end

    // request tracking, one operation in flight
    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy    <= 1'b0;
            ackSeen <= 1'b0;
            start   <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (busy && (ackSeen || ack) && !req) begin
                busy    <= 1'b0;
                ackSeen <= 1'b0;
            end else if (busy && ack) begin
                ackSeen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            boothValid <= 1'b0;
        end else begin
            boothValid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sign     <= x.fields.sign ^ y.fields.sign;
            expSum   <= $signed({2'b00, x.fields.exponent})
                      + $signed({2'b00, y.fields.exponent}) - expBias;
            specKind <= kind;
            fracFull <= sigX * sigY;
            rModeOut <= rMode;
        end
    end

    // ack belongs to the round stage, so this ties both ends of the handshake
    noAcceptDuringAck: assert property (@(posedge clk) disable iff (!rstN)
        accept |-> !ack);

endmodule

/* source/fpMulPkg.sv */
package fpMulPkg;

    // one binary32 word, seen whole or split into its fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        sign;
            logic [7:0]  exponent;
            logic [22:0] fraction;
        } fields;
    } fpWord;

    // rounding modes, codes above rmRmm fall back to nearest-even
    localparam logic [2:0] rmRne = 3'b000;
    localparam logic [2:0] rmRtz = 3'b001;
    localparam logic [2:0] rmRdn = 3'b010;
    localparam logic [2:0] rmRup = 3'b011;
    localparam logic [2:0] rmRmm = 3'b100;

    // operand class carried down the pipeline
    localparam logic [1:0] skNormal = 2'd0;
    localparam logic [1:0] skZero   = 2'd1;
    localparam logic [1:0] skInf    = 2'd2;
    localparam logic [1:0] skNan    = 2'd3;

    // canonical quiet NaN
    localparam logic [31:0] qNan = 32'h7FC0_0000;

    localparam logic signed [9:0] expBias = 10'sd127;

endpackage
